// File: src/zebra_params.svh
`ifndef ZEBRA_PARAMS_SVH
`define ZEBRA_PARAMS_SVH

// ==========================================================
// Frame geometry
// ==========================================================
`define ZD_IMG_WIDTH        32
`define ZD_IMG_HEIGHT       24

// Highest provisional label, label 0 is background
`define ZD_MAX_LABEL        15

// ==========================================================
// Detection thresholds
// ==========================================================
// Grey value at or above this is white
`define ZD_WHITE_THRESHOLD  180

// Inclusive area window for a stripe
`define ZD_MIN_BLOB_AREA    6
`define ZD_MAX_BLOB_AREA    120

// Stripes needed to call it a crossing
`define ZD_MIN_BLOBS        3

`endif

// File: src/pixel_pkg.sv
`default_nettype none

`include "zebra_params.svh"

package pixel_pkg;

    typedef logic [7:0] pixel_t;
    typedef logic [$clog2(`ZD_IMG_WIDTH)-1:0] x_t;
    typedef logic [$clog2(`ZD_IMG_HEIGHT)-1:0] y_t;

    // Raster address, row * width + column
    typedef logic [$clog2(`ZD_IMG_WIDTH * `ZD_IMG_HEIGHT)-1:0] pix_addr_t;

    // Scanner output, value comes straight from the frame memory
    typedef struct packed {
        logic   valid;
        x_t     x;
        y_t     y;
        logic   last;
        pixel_t value;
    } pix_beat_t;

    // Classifier output
    typedef struct packed {
        logic valid;
        x_t   x;
        y_t   y;
        logic last;
        logic white;
    } class_beat_t;

endpackage

`default_nettype wire

// File: src/blob_pkg.sv
`default_nettype none

`include "zebra_params.svh"

package blob_pkg;

    // Provisional label, 0 means background
    typedef logic [$clog2(`ZD_MAX_LABEL + 1)-1:0] label_t;

    // Enough for every pixel of the frame
    typedef logic [$clog2(`ZD_IMG_WIDTH * `ZD_IMG_HEIGHT + 1)-1:0] area_t;

    typedef logic [4:0] blob_cnt_t;

    // Labeler output stream
    typedef struct packed {
        logic   valid;
        logic   last;
        label_t label;
    } label_beat_t;

    // ==========================================================
    // Stage state machines
    // ==========================================================
    typedef enum logic [1:0] {
        scan_idle,
        scan_run,
        scan_drain
    } scan_state_t;

    typedef enum logic [1:0] {
        decide_idle,
        decide_sweep,
        decide_report
    } decide_state_t;

endpackage

`default_nettype wire

// File: src/frame_ram.sv
`timescale 1ns/1ns
`default_nettype none

`include "zebra_params.svh"

module frame_ram
    import pixel_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      we,
    input  wire pix_addr_t wr_addr,
    input  wire pixel_t    wr_data,
    input  wire pix_addr_t rd_addr,
    output pixel_t         rd_data
);

    localparam int DEPTH = `ZD_IMG_WIDTH * `ZD_IMG_HEIGHT;

    pixel_t mem [0:DEPTH-1];

    // Host side write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: src/raster_scanner.sv
`timescale 1ns/1ns
`default_nettype none

`include "zebra_params.svh"

module raster_scanner
    import pixel_pkg::*, blob_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire logic   start,
    input  wire logic   done,
    output logic        busy,
    output logic        scan_start,
    output pix_addr_t   rd_addr,
    input  wire pixel_t rd_data,
    output pix_beat_t   beat
);

    scan_state_t state;
    x_t          x_pos;
    y_t          y_pos;

    // Position of the pixel now on rd_data
    logic beat_valid;
    x_t   beat_x;
    y_t   beat_y;
    logic beat_last;

    logic at_row_end;
    logic at_frame_end;

    assign at_row_end   = (x_pos == x_t'(`ZD_IMG_WIDTH - 1));
    assign at_frame_end = at_row_end && (y_pos == y_t'(`ZD_IMG_HEIGHT - 1));

    assign rd_addr = pix_addr_t'(y_pos) * pix_addr_t'(`ZD_IMG_WIDTH) + pix_addr_t'(x_pos);
    assign busy    = (state != scan_idle);

    // ==========================================================
    // Control and address generation
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= scan_idle;
            x_pos      <= '0;
            y_pos      <= '0;
            scan_start <= 1'b0;
            beat_valid <= 1'b0;
            beat_x     <= '0;
            beat_y     <= '0;
            beat_last  <= 1'b0;
        end else begin
            scan_start <= 1'b0;
            beat_valid <= 1'b0;
            case (state)
                scan_idle: begin
                    if (start) begin
                        x_pos      <= '0;
                        y_pos      <= '0;
                        scan_start <= 1'b1;
                        state      <= scan_run;
                    end
                end
                scan_run: begin
                    beat_valid <= 1'b1;
                    beat_x     <= x_pos;
                    beat_y     <= y_pos;
                    beat_last  <= at_frame_end;
                    if (at_frame_end) begin
                        state <= scan_drain;
                    end else if (at_row_end) begin
                        x_pos <= '0;
                        y_pos <= y_pos + 1'b1;
                    end else begin
                        x_pos <= x_pos + 1'b1;
                    end
                end
                // Pipeline still busy downstream
                scan_drain: begin
                    if (done) begin
                        state <= scan_idle;
                    end
                end
                default: state <= scan_idle;
            endcase
        end
    end

    always_comb begin
        beat.valid = beat_valid;
        beat.x     = beat_x;
        beat.y     = beat_y;
        beat.last  = beat_last;
        beat.value = rd_data;
    end

endmodule

`default_nettype wire

// File: src/white_classifier.sv
`timescale 1ns/1ns
`default_nettype none

`include "zebra_params.svh"

module white_classifier
    import pixel_pkg::*, blob_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      scan_start,
    input  wire pix_beat_t in_beat,
    output class_beat_t    out_beat,
    output area_t          white_count
);

    logic is_white;

    assign is_white = (in_beat.value >= pixel_t'(`ZD_WHITE_THRESHOLD));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_beat    <= '0;
            white_count <= '0;
        end else begin
            out_beat.valid <= in_beat.valid;
            out_beat.x     <= in_beat.x;
            out_beat.y     <= in_beat.y;
            out_beat.last  <= in_beat.last;
            out_beat.white <= is_white;
            // New frame restarts the count
            if (scan_start) begin
                white_count <= '0;
            end else if (in_beat.valid && is_white) begin
                white_count <= white_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/component_labeler.sv
`timescale 1ns/1ns
`default_nettype none

`include "zebra_params.svh"

module component_labeler
    import pixel_pkg::*, blob_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        scan_start,
    input  wire class_beat_t in_beat,
    output label_beat_t      out_beat,
    output blob_cnt_t        blob_count
);

    // Labels of the previous row, one entry per column
    label_t row_buf [0:`ZD_IMG_WIDTH-1];

    label_t left_label;
    label_t next_label;

    label_t left_nbr;
    label_t above_nbr;
    label_t assigned;
    logic   take_new;

    // ==========================================================
    // Neighbour lookup and label choice
    // ==========================================================
    always_comb begin
        // Nothing to the left of column 0 or above row 0
        left_nbr  = (in_beat.x == '0) ? '0 : left_label;
        above_nbr = (in_beat.y == '0) ? '0 : row_buf[in_beat.x];
        take_new  = 1'b0;
        if (!in_beat.white) begin
            assigned = '0;
        end else if (left_nbr != '0 && above_nbr != '0) begin
            assigned = (left_nbr < above_nbr) ? left_nbr : above_nbr;
        end else if (left_nbr != '0) begin
            assigned = left_nbr;
        end else if (above_nbr != '0) begin
            assigned = above_nbr;
        end else begin
            assigned = next_label;
            take_new = 1'b1;
        end
    end

    // Row buffer, black pixels write 0
    always_ff @(posedge clk) begin
        if (in_beat.valid) begin
            row_buf[in_beat.x] <= assigned;
        end
    end

    // ==========================================================
    // Label allocation and output beat
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_beat   <= '0;
            left_label <= '0;
            next_label <= label_t'(1);
            blob_count <= '0;
        end else if (scan_start) begin
            out_beat   <= '0;
            left_label <= '0;
            next_label <= label_t'(1);
            blob_count <= '0;
        end else begin
            out_beat.valid <= in_beat.valid;
            out_beat.last  <= in_beat.last;
            out_beat.label <= assigned;
            if (in_beat.valid) begin
                left_label <= assigned;
                if (take_new) begin
                    // Out of labels, keep reusing the highest one
                    if (next_label != label_t'(`ZD_MAX_LABEL)) begin
                        next_label <= next_label + 1'b1;
                    end
                    if (blob_count != blob_cnt_t'(`ZD_MAX_LABEL)) begin
                        blob_count <= blob_count + 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/blob_area_accum.sv
`timescale 1ns/1ns
`default_nettype none

`include "zebra_params.svh"

module blob_area_accum
    import blob_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        scan_start,
    input  wire label_beat_t in_beat,
    output logic             frame_end,
    input  wire label_t      sweep_label,
    output area_t            sweep_area,
    input  wire label_t      area_label,
    output area_t            area_value
);

    // Entry 0 is background and never counts up
    area_t area_cnt [0:`ZD_MAX_LABEL];

    logic count_en;

    assign count_en = in_beat.valid && (in_beat.label != '0);

    // ==========================================================
    // Area counters
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i <= `ZD_MAX_LABEL; i++) begin
                area_cnt[i] <= '0;
            end
        end else if (scan_start) begin
            for (int i = 0; i <= `ZD_MAX_LABEL; i++) begin
                area_cnt[i] <= '0;
            end
        end else if (count_en) begin
            area_cnt[in_beat.label] <= area_cnt[in_beat.label] + 1'b1;
        end
    end

    // Last beat has been counted by the time this is seen
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_end <= 1'b0;
        end else begin
            frame_end <= in_beat.valid && in_beat.last;
        end
    end

    // Read ports
    assign sweep_area = area_cnt[sweep_label];
    assign area_value = area_cnt[area_label];

endmodule

`default_nettype wire

// File: src/crossing_decider.sv
`timescale 1ns/1ns
`default_nettype none

`include "zebra_params.svh"

module crossing_decider
    import blob_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  frame_end,
    output label_t     sweep_label,
    input  wire area_t sweep_area,
    output blob_cnt_t  valid_blob_count,
    output logic       zebra_detected,
    output logic       done
);

    decide_state_t state;
    blob_cnt_t     run_count;
    logic          in_window;

    assign in_window = (sweep_area >= area_t'(`ZD_MIN_BLOB_AREA)) &&
                       (sweep_area <= area_t'(`ZD_MAX_BLOB_AREA));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state            <= decide_idle;
            sweep_label      <= '0;
            run_count        <= '0;
            valid_blob_count <= '0;
            zebra_detected   <= 1'b0;
            done             <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                decide_idle: begin
                    if (frame_end) begin
                        sweep_label <= label_t'(1);
                        run_count   <= '0;
                        state       <= decide_sweep;
                    end
                end
                // One label per cycle
                decide_sweep: begin
                    if (in_window) begin
                        run_count <= run_count + 1'b1;
                    end
                    if (sweep_label == label_t'(`ZD_MAX_LABEL)) begin
                        state <= decide_report;
                    end else begin
                        sweep_label <= sweep_label + 1'b1;
                    end
                end
                // Results stay put until the next report
                decide_report: begin
                    valid_blob_count <= run_count;
                    zebra_detected   <= (run_count >= blob_cnt_t'(`ZD_MIN_BLOBS));
                    done             <= 1'b1;
                    sweep_label      <= '0;
                    state            <= decide_idle;
                end
                default: state <= decide_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/zebra_detector_top.sv
`timescale 1ns/1ns
`default_nettype none

module zebra_detector_top
    import pixel_pkg::*, blob_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      start,
    output logic           busy,
    output logic           done,
    input  wire logic      pix_we,
    input  wire pix_addr_t pix_wr_addr,
    input  wire pixel_t    pix_wr_data,
    input  wire label_t    area_label,
    output area_t          area_value,
    output area_t          white_count,
    output blob_cnt_t      blob_count,
    output blob_cnt_t      valid_blob_count,
    output logic           zebra_detected
);

    pix_addr_t   rd_addr;
    pixel_t      rd_data;
    logic        scan_start;
    pix_beat_t   pix_beat;
    class_beat_t class_beat;
    label_beat_t label_beat;
    logic        frame_end;
    label_t      sweep_label;
    area_t       sweep_area;

    // ==========================================================
    // Frame memory and scan front end
    // ==========================================================
    frame_ram i_frame_ram (
        .clk     (clk),
        .we      (pix_we),
        .wr_addr (pix_wr_addr),
        .wr_data (pix_wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    raster_scanner i_raster_scanner (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .done       (done),
        .busy       (busy),
        .scan_start (scan_start),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .beat       (pix_beat)
    );

    // ==========================================================
    // Pixel pipeline
    // ==========================================================
    white_classifier i_white_classifier (
        .clk         (clk),
        .rst_n       (rst_n),
        .scan_start  (scan_start),
        .in_beat     (pix_beat),
        .out_beat    (class_beat),
        .white_count (white_count)
    );

    component_labeler i_component_labeler (
        .clk        (clk),
        .rst_n      (rst_n),
        .scan_start (scan_start),
        .in_beat    (class_beat),
        .out_beat   (label_beat),
        .blob_count (blob_count)
    );

    blob_area_accum i_blob_area_accum (
        .clk         (clk),
        .rst_n       (rst_n),
        .scan_start  (scan_start),
        .in_beat     (label_beat),
        .frame_end   (frame_end),
        .sweep_label (sweep_label),
        .sweep_area  (sweep_area),
        .area_label  (area_label),
        .area_value  (area_value)
    );

    crossing_decider i_crossing_decider (
        .clk              (clk),
        .rst_n            (rst_n),
        .frame_end        (frame_end),
        .sweep_label      (sweep_label),
        .sweep_area       (sweep_area),
        .valid_blob_count (valid_blob_count),
        .zebra_detected   (zebra_detected),
        .done             (done)
    );

endmodule

`default_nettype wire

// File: test/tb_scenes.svh
`ifndef TB_SCENES_SVH
`define TB_SCENES_SVH

`include "zebra_params.svh"

// ============================================================
// Scene builders
// ============================================================

// Grey levels that change with the whole address
function automatic pixel_t dark_value(input int addr);
    return pixel_t'((addr * 37 + addr / 7) % `ZD_WHITE_THRESHOLD);
endfunction

function automatic pixel_t light_value(input int addr);
    return pixel_t'(`ZD_WHITE_THRESHOLD +
                    (addr * 13 + addr / 11) % (256 - `ZD_WHITE_THRESHOLD));
endfunction

task automatic scene_black();
    for (int a = 0; a < FRAME_PIXELS; a++) begin
        frame_img[a] = dark_value(a);
    end
endtask

task automatic paint_white(input int x0, input int y0, input int w, input int h);
    int addr;
    for (int y = y0; y < y0 + h; y++) begin
        for (int x = x0; x < x0 + w; x++) begin
            addr = y * `ZD_IMG_WIDTH + x;
            frame_img[addr] = light_value(addr);
        end
    end
endtask

// Bars of 3 rows, one black row between them
task automatic scene_bars();
    scene_black();
    for (int b = 0; b < 4; b++) begin
        paint_white(0, 4 * b, `ZD_IMG_WIDTH, 3);
    end
endtask

// Checkerboard of values right at the threshold and one below
task automatic scene_threshold();
    for (int a = 0; a < FRAME_PIXELS; a++) begin
        if ((a % `ZD_IMG_WIDTH + a / `ZD_IMG_WIDTH) % 2 == 0) begin
            frame_img[a] = pixel_t'(`ZD_WHITE_THRESHOLD);
        end else begin
            frame_img[a] = pixel_t'(`ZD_WHITE_THRESHOLD - 1);
        end
    end
endtask

// Three tiny blobs, one 3x3 blob and one oversized block
task automatic scene_area_filter();
    scene_black();
    paint_white(2, 2, 2, 1);
    paint_white(10, 5, 2, 1);
    paint_white(20, 8, 2, 1);
    paint_white(5, 11, 3, 3);
    paint_white(0, 16, `ZD_IMG_WIDTH, 8);
endtask

task automatic scene_random(input int density);
    for (int a = 0; a < FRAME_PIXELS; a++) begin
        if ($urandom % 100 < density) begin
            frame_img[a] = light_value(a);
        end else begin
            frame_img[a] = dark_value(a);
        end
    end
endtask

// ============================================================
// Reference model, single pass with the min rule
// ============================================================
task automatic model_frame();
    int row_lab [0:`ZD_IMG_WIDTH-1];
    int left_lab;
    int above_lab;
    int cur;
    int next_free;
    int new_blobs;
    int addr;
    exp_white = 0;
    exp_valid = 0;
    next_free = 1;
    new_blobs = 0;
    cur       = 0;
    for (int lab = 0; lab <= `ZD_MAX_LABEL; lab++) begin
        exp_area[lab] = 0;
    end
    for (int y = 0; y < `ZD_IMG_HEIGHT; y++) begin
        for (int x = 0; x < `ZD_IMG_WIDTH; x++) begin
            addr      = y * `ZD_IMG_WIDTH + x;
            left_lab  = (x == 0) ? 0 : cur;
            above_lab = (y == 0) ? 0 : row_lab[x];
            cur       = 0;
            if (frame_img[addr] >= `ZD_WHITE_THRESHOLD) begin
                exp_white++;
                if (left_lab != 0 && above_lab != 0) begin
                    cur = (left_lab < above_lab) ? left_lab : above_lab;
                end else if (left_lab != 0) begin
                    cur = left_lab;
                end else if (above_lab != 0) begin
                    cur = above_lab;
                end else begin
                    // New blob, the last label is shared once all are used
                    cur = next_free;
                    new_blobs++;
                    if (next_free < `ZD_MAX_LABEL) begin
                        next_free++;
                    end
                end
            end
            row_lab[x] = cur;
            if (cur != 0) begin
                exp_area[cur]++;
            end
        end
    end
    exp_blobs = (new_blobs > `ZD_MAX_LABEL) ? `ZD_MAX_LABEL : new_blobs;
    for (int lab = 1; lab <= `ZD_MAX_LABEL; lab++) begin
        if (exp_area[lab] >= `ZD_MIN_BLOB_AREA && exp_area[lab] <= `ZD_MAX_BLOB_AREA) begin
            exp_valid++;
        end
    end
    exp_zebra = (exp_valid >= `ZD_MIN_BLOBS) ? 1 : 0;
endtask

`endif

// File: test/tb_zebra_detector.sv
`timescale 1ns/1ns
`default_nettype none

`include "zebra_params.svh"

module tb_zebra_detector
    import pixel_pkg::*, blob_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int FRAME_PIXELS = `ZD_IMG_WIDTH * `ZD_IMG_HEIGHT;
    localparam int DONE_LIMIT   = 1000;
    // Lands after the last beat while the pipeline drains
    localparam int POKE_DELAY   = FRAME_PIXELS + 4;
    // Ten scans with their frame loads and area readouts
    localparam int RUN_COUNT    = 10;
    localparam int RUN_CYCLES   = 800 + FRAME_PIXELS + 150;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      start;
    logic      busy;
    logic      done;
    logic      pix_we;
    pix_addr_t pix_wr_addr;
    pixel_t    pix_wr_data;
    label_t    area_label;
    area_t     area_value;
    area_t     white_count;
    blob_cnt_t blob_count;
    blob_cnt_t valid_blob_count;
    logic      zebra_detected;

    string  test_name = "reset";
    int     error_count = 0;
    int     done_count;
    pixel_t frame_img [0:FRAME_PIXELS-1];

    // Expected results from the model
    int exp_white;
    int exp_blobs;
    int exp_valid;
    int exp_zebra;
    int exp_area [0:`ZD_MAX_LABEL];

    // Results as seen at the last done
    logic      held_ok = 1'b0;
    area_t     held_white;
    blob_cnt_t held_blobs;
    blob_cnt_t held_valid;
    logic      held_zebra;

    `include "tb_scenes.svh"

    zebra_detector_top i_zebra_detector_top (
        .clk              (clk),
        .rst_n            (rst_n),
        .start            (start),
        .busy             (busy),
        .done             (done),
        .pix_we           (pix_we),
        .pix_wr_addr      (pix_wr_addr),
        .pix_wr_data      (pix_wr_data),
        .area_label       (area_label),
        .area_value       (area_value),
        .white_count      (white_count),
        .blob_count       (blob_count),
        .valid_blob_count (valid_blob_count),
        .zebra_detected   (zebra_detected)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_count <= 0;
        end else if (done) begin
            done_count <= done_count + 1;
        end
    end

    // ============================================================
    // Checks that run on every cycle
    // ============================================================
    always @(negedge clk) begin
        if (rst_n && done) begin
            assert (busy) else begin
                $display("done was high while busy was low in test %s", test_name);
                abort_run();
            end
            held_white = white_count;
            held_blobs = blob_count;
            held_valid = valid_blob_count;
            held_zebra = zebra_detected;
            held_ok    = 1'b1;
        end else if (rst_n && !busy && held_ok) begin
            assert (white_count == held_white && blob_count == held_blobs &&
                    valid_blob_count == held_valid && zebra_detected == held_zebra) else begin
                $display("results changed while idle in test %s", test_name);
                abort_run();
            end
        end
    end

    task automatic abort_run();
        error_count++;
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("mismatch %s %s: expected %0d, actual %0d",
                     test_name, what, expected, actual);
            abort_run();
        end
    endtask

    task automatic load_frame();
        for (int a = 0; a < FRAME_PIXELS; a++) begin
            @(posedge clk);
            pix_we      <= 1'b1;
            pix_wr_addr <= pix_addr_t'(a);
            pix_wr_data <= frame_img[a];
        end
        @(posedge clk);
        pix_we <= 1'b0;
    endtask

    // Load, start, optionally poke start again while draining, wait for done
    task automatic scan_frame(input bit poke_busy);
        int waited;
        int dones_before;
        load_frame();
        dones_before = done_count;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_value("busy after start", 1, busy);
        if (poke_busy) begin
            repeat (POKE_DELAY) @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
        end
        waited = 0;
        while (!done && waited < DONE_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            $display("no done within %0d cycles in test %s", DONE_LIMIT, test_name);
            abort_run();
        end
        repeat (4) @(negedge clk);
        check_value("done pulses", dones_before + 1, done_count);
        check_value("busy after done", 0, busy);
    endtask

    task automatic check_area(input int lab, input int expected);
        @(posedge clk);
        area_label <= label_t'(lab);
        @(negedge clk);
        check_value($sformatf("area_value[%0d]", lab), expected, area_value);
    endtask

    task automatic check_results();
        model_frame();
        check_value("white_count", exp_white, white_count);
        check_value("blob_count", exp_blobs, blob_count);
        check_value("valid_blob_count", exp_valid, valid_blob_count);
        check_value("zebra_detected", exp_zebra, zebra_detected);
        for (int lab = 0; lab <= `ZD_MAX_LABEL; lab++) begin
            check_area(lab, exp_area[lab]);
        end
    endtask

    task automatic random_test(input int density);
        test_name = $sformatf("random_%0d", density);
        scene_random(density);
        scan_frame(1'b0);
        check_results();
    endtask

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        void'($urandom(78));
        rst_n       <= 1'b0;
        start       <= 1'b0;
        pix_we      <= 1'b0;
        pix_wr_addr <= '0;
        pix_wr_data <= '0;
        area_label  <= '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("busy", 0, busy);
        check_value("done", 0, done);
        check_value("zebra_detected", 0, zebra_detected);
        check_value("white_count", 0, white_count);
        check_value("blob_count", 0, blob_count);
        check_value("valid_blob_count", 0, valid_blob_count);

        test_name = "all_black";
        scene_black();
        scan_frame(1'b0);
        check_value("white_count", 0, white_count);
        check_value("blob_count", 0, blob_count);
        check_value("zebra_detected", 0, zebra_detected);
        check_results();

        test_name = "four_bars";
        scene_bars();
        scan_frame(1'b0);
        check_value("blob_count", 4, blob_count);
        check_value("valid_blob_count", 4, valid_blob_count);
        check_value("zebra_detected", 1, zebra_detected);
        for (int lab = 1; lab <= 4; lab++) begin
            check_area(lab, 96);
        end
        check_results();

        test_name = "threshold_edge";
        scene_threshold();
        scan_frame(1'b0);
        check_value("white_count", FRAME_PIXELS / 2, white_count);
        check_results();

        test_name = "area_window";
        scene_area_filter();
        scan_frame(1'b0);
        check_value("blob_count", 5, blob_count);
        check_value("valid_blob_count", 1, valid_blob_count);
        check_value("zebra_detected", 0, zebra_detected);
        check_results();

        random_test(5);
        random_test(15);
        random_test(50);
        random_test(85);

        // Second frame differs, so stale counters would show up
        test_name = "back_to_back_a";
        scene_random(35);
        scan_frame(1'b1);
        check_results();
        test_name = "back_to_back_b";
        scene_area_filter();
        scan_frame(1'b0);
        check_results();

        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #((RUN_COUNT * RUN_CYCLES + 200) * CLK_PERIOD);
        $display("watchdog expired in test %s", test_name);
        abort_run();
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+src
+incdir+test
src/pixel_pkg.sv
src/blob_pkg.sv
src/frame_ram.sv
src/raster_scanner.sv
src/white_classifier.sv
src/component_labeler.sv
src/blob_area_accum.sv
src/crossing_decider.sv
src/zebra_detector_top.sv
test/tb_zebra_detector.sv
